// ==== hw/ft_pkg.sv ====
package ft_pkg;

	////////////////////////////////////////////////////////////
	// Widths and codes

	// One GMII data byte
	typedef logic [7:0] byte_t;

	// In-band speed code as reported by the PHY
	typedef logic [1:0] spd_t;

	localparam spd_t SPD_10   = 2'd0;
	localparam spd_t SPD_100  = 2'd1;
	localparam spd_t SPD_1000 = 2'd2;

	// Redundant PHY ports
	localparam int PORT_NUM = 2;

	typedef logic [$clog2(PORT_NUM)-1:0] port_t;

	// Status filter length
	localparam int unsigned DEBOUNCE_W = 5;
	localparam logic [DEBOUNCE_W-1:0] DEBOUNCE_CYCLES = 5'd16;

	////////////////////////////////////////////////////////////
	// Bundles

	// In-band status of one PHY
	typedef struct packed {
		logic up;
		spd_t spd;
		logic dplx;
	} ibs_t;

	// One GMII direction, dv is rxdv or txen
	typedef struct packed {
		byte_t dat;
		logic  dv;
		logic  er;
	} gmii_t;

	// Link status seen by the MAC
	typedef struct packed {
		logic  up;
		port_t port;
		spd_t  spd;
		logic  dplx;
	} link_t;

	// Failover FSM
	typedef enum logic {
		FT_NO_LINK,
		FT_ACTIVE
	} ft_state_t;

endpackage

// ==== hw/link_monitor.sv ====
`timescale 1ns/1ps

module link_monitor (
	input  logic         clk_i,
	input  logic         arst_n_i,
	input  ft_pkg::ibs_t ibs_i,
	output ft_pkg::ibs_t ibs_o
);

	// Last raw sample and how long it has held
	ft_pkg::ibs_t sample_q;
	logic [ft_pkg::DEBOUNCE_W-1:0] run_q;
	logic run_done;

	// Filtered status
	ft_pkg::ibs_t stable_q;

	assign run_done = (run_q == ft_pkg::DEBOUNCE_CYCLES);

	////////////////////////////////////////////////////////////
	// Run counter

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sample_q <= '{up: 1'b0, spd: ft_pkg::SPD_10, dplx: 1'b0};
			run_q    <= '0;
		end else if (ibs_i != sample_q) begin
			// New value, first cycle of its run
			sample_q <= ibs_i;
			run_q    <= 1;
		end else if (!run_done) begin
			run_q <= run_q + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Accept once the run is long enough

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			stable_q <= '{up: 1'b0, spd: ft_pkg::SPD_10, dplx: 1'b0};
		end else if (run_done) begin
			stable_q <= sample_q;
		end
	end

	assign ibs_o = stable_q;

endmodule

// ==== hw/failover_ctrl.sv ====
`timescale 1ns/1ps

module failover_ctrl (
	input  logic          clk_i,
	input  logic          arst_n_i,
	input  ft_pkg::ibs_t  ibs0_i,
	input  ft_pkg::ibs_t  ibs1_i,
	input  logic          rx_busy_i,
	input  logic          tx_busy_i,
	output ft_pkg::link_t link_o,
	output logic          link_change_o
);

	ft_pkg::ft_state_t state_q;
	ft_pkg::ft_state_t state_d;

	ft_pkg::link_t link_q;
	ft_pkg::link_t link_d;

	logic change_q;
	logic change_d;

	// Status of the active port and of its partner
	ft_pkg::ibs_t act_ibs;
	ft_pkg::ibs_t oth_ibs;

	// Both directions between frames
	logic idle;

	assign act_ibs = link_q.port[0] ? ibs1_i : ibs0_i;
	assign oth_ibs = link_q.port[0] ? ibs0_i : ibs1_i;
	assign idle    = !rx_busy_i && !tx_busy_i;

	////////////////////////////////////////////////////////////
	// Next state

	always_comb begin
		state_d = state_q;
		link_d  = link_q;

		unique case (state_q)
			ft_pkg::FT_NO_LINK: begin
				// Port 0 wins when both are up
				if (ibs0_i.up) begin
					state_d     = ft_pkg::FT_ACTIVE;
					link_d.up   = 1'b1;
					link_d.port = 1'b0;
					link_d.spd  = ibs0_i.spd;
					link_d.dplx = ibs0_i.dplx;
				end else if (ibs1_i.up) begin
					state_d     = ft_pkg::FT_ACTIVE;
					link_d.up   = 1'b1;
					link_d.port = 1'b1;
					link_d.spd  = ibs1_i.spd;
					link_d.dplx = ibs1_i.dplx;
				end
			end

			ft_pkg::FT_ACTIVE: begin
				if (act_ibs.up) begin
					// Stay put, track speed and duplex
					link_d.spd  = act_ibs.spd;
					link_d.dplx = act_ibs.dplx;
				end else if (!oth_ibs.up) begin
					state_d   = ft_pkg::FT_NO_LINK;
					link_d.up = 1'b0;
				end else if (idle) begin
					// Swap only at a frame boundary
					link_d.port = ~link_q.port;
					link_d.spd  = oth_ibs.spd;
					link_d.dplx = oth_ibs.dplx;
				end
			end
		endcase
	end

	assign change_d = (link_d.up != link_q.up) || (link_d.port != link_q.port);

	////////////////////////////////////////////////////////////
	// Registers

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q  <= ft_pkg::FT_NO_LINK;
			link_q   <= '{up: 1'b0, port: 1'b0, spd: ft_pkg::SPD_10, dplx: 1'b0};
			change_q <= 1'b0;
		end else begin
			state_q  <= state_d;
			link_q   <= link_d;
			change_q <= change_d;
		end
	end

	assign link_o        = link_q;
	assign link_change_o = change_q;

endmodule

// ==== hw/rx_select.sv ====
`timescale 1ns/1ps

module rx_select (
	input  logic          clk_i,
	input  logic          arst_n_i,
	input  ft_pkg::gmii_t phy0_rx_i,
	input  ft_pkg::gmii_t phy1_rx_i,
	input  ft_pkg::link_t link_i,
	output ft_pkg::gmii_t mac_rx_o,
	output logic          rx_busy_o
);

	// Stream of the currently selected port
	ft_pkg::gmii_t sel_rx;

	// Output stage toward the MAC
	ft_pkg::gmii_t rx_q;

	assign sel_rx = link_i.port[0] ? phy1_rx_i : phy0_rx_i;

	////////////////////////////////////////////////////////////
	// Receive path

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rx_q <= '0;
		end else if (link_i.up) begin
			rx_q <= sel_rx;
		end else begin
			// No link so nothing reaches the MAC
			rx_q <= '0;
		end
	end

	assign mac_rx_o = rx_q;

	// Frame in flight on the active port
	assign rx_busy_o = sel_rx.dv;

endmodule

// ==== hw/tx_steer.sv ====
`timescale 1ns/1ps

module tx_steer (
	input  logic          clk_i,
	input  logic          arst_n_i,
	input  ft_pkg::gmii_t mac_tx_i,
	input  ft_pkg::link_t link_i,
	output ft_pkg::gmii_t phy0_tx_o,
	output ft_pkg::gmii_t phy1_tx_o,
	output logic          tx_busy_o
);

	// Port enables
	logic en0;
	logic en1;

	ft_pkg::gmii_t tx0_q;
	ft_pkg::gmii_t tx1_q;

	assign en0 = link_i.up && (link_i.port == 1'b0);
	assign en1 = link_i.up && (link_i.port == 1'b1);

	////////////////////////////////////////////////////////////
	// Transmit path

	// Inactive port sees idle
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tx0_q <= '0;
			tx1_q <= '0;
		end else begin
			tx0_q <= en0 ? mac_tx_i : '0;
			tx1_q <= en1 ? mac_tx_i : '0;
		end
	end

	assign phy0_tx_o = tx0_q;
	assign phy1_tx_o = tx1_q;

	assign tx_busy_o = mac_tx_i.dv;

endmodule

// ==== hw/phy_ft_top.sv ====
`timescale 1ns/1ps

module phy_ft_top (
	input  logic          clk_i,
	input  logic          arst_n_i,

	// In-band status from both PHYs
	input  ft_pkg::ibs_t  phy0_ibs_i,
	input  ft_pkg::ibs_t  phy1_ibs_i,

	// Receive side
	input  ft_pkg::gmii_t phy0_rx_i,
	input  ft_pkg::gmii_t phy1_rx_i,
	output ft_pkg::gmii_t mac_rx_o,

	// Transmit side
	input  ft_pkg::gmii_t mac_tx_i,
	output ft_pkg::gmii_t phy0_tx_o,
	output ft_pkg::gmii_t phy1_tx_o,

	// Status toward the MAC
	output ft_pkg::link_t link_o,
	output logic          link_change_o
);

	ft_pkg::ibs_t  ibs0;
	ft_pkg::ibs_t  ibs1;
	ft_pkg::link_t link;
	logic          rx_busy;
	logic          tx_busy;

	////////////////////////////////////////////////////////////
	// Status filters

	link_monitor mon0 (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.ibs_i    (phy0_ibs_i),
		.ibs_o    (ibs0)
	);

	link_monitor mon1 (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.ibs_i    (phy1_ibs_i),
		.ibs_o    (ibs1)
	);

	////////////////////////////////////////////////////////////
	// Port selection

	failover_ctrl ctrl (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.ibs0_i        (ibs0),
		.ibs1_i        (ibs1),
		.rx_busy_i     (rx_busy),
		.tx_busy_i     (tx_busy),
		.link_o        (link),
		.link_change_o (link_change_o)
	);

	////////////////////////////////////////////////////////////
	// Data paths

	rx_select rx_sel (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.phy0_rx_i (phy0_rx_i),
		.phy1_rx_i (phy1_rx_i),
		.link_i    (link),
		.mac_rx_o  (mac_rx_o),
		.rx_busy_o (rx_busy)
	);

	tx_steer tx_str (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.mac_tx_i  (mac_tx_i),
		.link_i    (link),
		.phy0_tx_o (phy0_tx_o),
		.phy1_tx_o (phy1_tx_o),
		.tx_busy_o (tx_busy)
	);

	assign link_o = link;

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// Reset held for 8 cycles, released away from the rising edge
	initial begin
		arst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end

endmodule

// ==== sim/phy_ft_tb.sv ====
`timescale 1ns/1ps

module phy_ft_tb;

	localparam logic [31:0] SEED = 32'h1ed10f79;
	localparam int FRAMES = 16;
	localparam int ACQ_CYCLES = int'(ft_pkg::DEBOUNCE_CYCLES) + 2;
	// About twice the summed test lengths
	localparam int CYCLE_LIMIT = 3000;

	typedef struct packed {
		ft_pkg::ibs_t last;
		logic [ft_pkg::DEBOUNCE_W-1:0] held;
		ft_pkg::ibs_t stb;
	} filt_t;

	typedef struct packed {
		filt_t         f0;
		filt_t         f1;
		ft_pkg::link_t link;
		logic          change;
		ft_pkg::gmii_t rx;
		ft_pkg::gmii_t tx0;
		ft_pkg::gmii_t tx1;
	} model_t;

	logic          clk;
	logic          arst_n;
	ft_pkg::ibs_t  ibs0;
	ft_pkg::ibs_t  ibs1;
	ft_pkg::gmii_t rx0;
	ft_pkg::gmii_t rx1;
	ft_pkg::gmii_t mac_tx;
	ft_pkg::gmii_t mac_rx;
	ft_pkg::gmii_t phy0_tx;
	ft_pkg::gmii_t phy1_tx;
	ft_pkg::link_t link;
	logic          link_change;

	model_t      exp_q;
	logic [31:0] rng = SEED;
	string       test_name;
	int          err_cnt = 0;
	int          test_err = 0;
	int          pass_cnt = 0;
	int          cycles = 0;
	int          n;

	tb_clk_gen clk_gen (.clk_o(clk), .arst_n_o(arst_n));

	phy_ft_top dut0 (
		.clk_i(clk), .arst_n_i(arst_n),
		.phy0_ibs_i(ibs0), .phy1_ibs_i(ibs1),
		.phy0_rx_i(rx0), .phy1_rx_i(rx1), .mac_rx_o(mac_rx),
		.mac_tx_i(mac_tx), .phy0_tx_o(phy0_tx), .phy1_tx_o(phy1_tx),
		.link_o(link), .link_change_o(link_change)
	);

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Status accepted once it has held for DEBOUNCE_CYCLES samples
	function automatic filt_t filter_step(filt_t f, ft_pkg::ibs_t raw);
		filt_t nx;
		nx = f;
		if (f.held == ft_pkg::DEBOUNCE_CYCLES)
			nx.stb = f.last;
		if (raw != f.last) begin
			nx.last = raw;
			nx.held = 1;
		end else if (f.held != ft_pkg::DEBOUNCE_CYCLES) begin
			nx.held = f.held + 1'b1;
		end
		return nx;
	endfunction

	function automatic model_t model_step(model_t m, ft_pkg::ibs_t raw0, ft_pkg::ibs_t raw1,
		ft_pkg::gmii_t in0, ft_pkg::gmii_t in1, ft_pkg::gmii_t tx);
		model_t       nx;
		ft_pkg::ibs_t act;
		ft_pkg::ibs_t oth;
		ft_pkg::ibs_t sel;
		logic         busy;
		nx = m;
		nx.f0 = filter_step(m.f0, raw0);
		nx.f1 = filter_step(m.f1, raw1);
		act = m.link.port ? m.f1.stb : m.f0.stb;
		oth = m.link.port ? m.f0.stb : m.f1.stb;
		busy = (m.link.port ? in1.dv : in0.dv) || tx.dv;
		if (!m.link.up && (m.f0.stb.up || m.f1.stb.up)) begin
			// Port 0 preferred
			nx.link.up = 1'b1;
			nx.link.port = !m.f0.stb.up;
		end else if (m.link.up && !act.up) begin
			if (!oth.up)
				nx.link.up = 1'b0;
			else if (!busy)
				nx.link.port = !m.link.port;
		end
		sel = nx.link.port ? m.f1.stb : m.f0.stb;
		if (nx.link.up && sel.up) begin
			nx.link.spd = sel.spd;
			nx.link.dplx = sel.dplx;
		end
		nx.change = (nx.link.up != m.link.up) || (nx.link.port != m.link.port);
		nx.rx = m.link.up ? (m.link.port ? in1 : in0) : '0;
		nx.tx0 = (m.link.up && !m.link.port) ? tx : '0;
		nx.tx1 = (m.link.up && m.link.port) ? tx : '0;
		return nx;
	endfunction

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			exp_q <= '0;
		else
			exp_q <= model_step(exp_q, ibs0, ibs1, rx0, rx1, mac_tx);
	end

	////////////////////////////////////////////////////////////
	// Checking

	task automatic check(string sig, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("ERR %s %s expected %h actual %h", test_name, sig, exp, act);
		end
	endtask

	always @(negedge clk) begin
		check("link_o", 32'(exp_q.link), 32'(link));
		check("link_change_o", 32'(exp_q.change), 32'(link_change));
		check("mac_rx_o", 32'(exp_q.rx), 32'(mac_rx));
		check("phy0_tx_o", 32'(exp_q.tx0), 32'(phy0_tx));
		check("phy1_tx_o", 32'(exp_q.tx1), 32'(phy1_tx));
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	task automatic tick(int cnt = 1);
		repeat (cnt) begin
			@(posedge clk);
			#1;
		end
	endtask

	function automatic ft_pkg::gmii_t rand_gmii();
		rng = xorshift(rng);
		return '{dat: rng[7:0], dv: 1'b1, er: 1'b0};
	endfunction

	task automatic send_frames(logic do_rx, logic do_tx, int count);
		int len;
		repeat (count) begin
			rng = xorshift(rng);
			len = 16 + int'(rng[12:8]);
			repeat (len) begin
				if (do_rx) begin
					rx0 = rand_gmii();
					rx1 = rand_gmii();
				end
				if (do_tx)
					mac_tx = rand_gmii();
				tick();
			end
			rx0 = '0;
			rx1 = '0;
			mac_tx = '0;
			tick(3);
		end
	endtask

	// Rising edges from the last drive up to the link change pulse
	task automatic wait_change(output int cnt);
		cnt = 0;
		do begin
			tick();
			cnt++;
		end while (!link_change);
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_err = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == test_err)
			pass_cnt++;
		$display("%s: %s", test_name, (err_cnt == test_err) ? "ok" : "errors");
	endtask

	initial begin
		ibs0 = '0;
		ibs1 = '0;
		rx0 = '0;
		rx1 = '0;
		mac_tx = '0;

		begin_test("reset");
		@(negedge clk);
		check("link_o", 0, 32'(link));
		check("link_change_o", 0, 32'(link_change));
		check("mac_rx_o", 0, 32'(mac_rx));
		check("phy_tx", 0, 32'({phy0_tx, phy1_tx}));
		@(posedge arst_n);
		tick(4);
		end_test();

		begin_test("acquire");
		ibs1 = '{up: 1'b1, spd: ft_pkg::SPD_1000, dplx: 1'b1};
		wait_change(n);
		check("acq_cycles", ACQ_CYCLES, n);
		check("port", 1, 32'(link.port));
		ibs0 = '{up: 1'b1, spd: ft_pkg::SPD_100, dplx: 1'b0};
		tick(2 * ACQ_CYCLES);
		check("no_revert", 1, 32'(link.port));
		ibs0.up = 1'b0;
		ibs1.up = 1'b0;
		wait_change(n);
		check("link_up", 0, 32'(link.up));
		ibs0.up = 1'b1;
		ibs1.up = 1'b1;
		wait_change(n);
		check("both_up_port", 0, 32'(link.port));
		end_test();

		begin_test("rx_forward");
		send_frames(1'b1, 1'b0, FRAMES);
		end_test();

		begin_test("tx_steer");
		send_frames(1'b0, 1'b1, FRAMES);
		end_test();

		begin_test("failover");
		for (int i = 0; i < 40; i++) begin
			mac_tx = rand_gmii();
			if (i == 4)
				ibs0.up = 1'b0;
			tick();
		end
		check("held_port", 0, 32'(link.port));
		mac_tx = '0;
		wait_change(n);
		// First cycle with both directions idle
		check("switch_cycles", 1, n);
		check("new_port", 1, 32'(link.port));
		check("new_spd", 32'(ft_pkg::SPD_1000), 32'(link.spd));
		check("new_dplx", 1, 32'(link.dplx));
		end_test();

		begin_test("glitch_loss");
		ibs1.up = 1'b0;
		tick(int'(ft_pkg::DEBOUNCE_CYCLES) / 2);
		ibs1.up = 1'b1;
		tick(2 * ACQ_CYCLES);
		check("glitch_up", 1, 32'(link.up));
		ibs1.up = 1'b0;
		wait_change(n);
		check("loss_up", 0, 32'(link.up));
		send_frames(1'b1, 1'b1, 4);
		end_test();

		$display("Tests passed: %0d, errors: %0d", pass_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== phy_ft_top.f ====
hw/ft_pkg.sv
hw/link_monitor.sv
hw/failover_ctrl.sv
hw/rx_select.sv
hw/tx_steer.sv
hw/phy_ft_top.sv
sim/tb_clk_gen.sv
sim/phy_ft_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and scan the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --top-module phy_ft_tb -f phy_ft_top.f -o phy_ft_sim \
	&& ./obj_dir/phy_ft_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
